// ==== src/ddrc_ctrl_pkg.sv ====
`default_nettype none

package ddrc_ctrl_pkg;

    typedef logic [31:0] wdata_t;     // bus write word
    typedef logic [7:0]  pattern_t;   // dqs or dqm byte pattern
    typedef logic [3:0]  tri_pat_t;   // one tri-state on/off nibble
    typedef logic [3:0]  wbuf_dly_t;  // extra write-buffer enable delay, cycles
    typedef logic [7:0]  dly_data_t;  // fine delay value
    typedef logic [6:0]  dly_addr_t;  // delay register select
    typedef logic [10:0] run_addr_t;  // sequencer start, msb = auto/manual
    typedef logic [3:0]  run_chn_t;   // sequencer channel
    typedef logic [12:0] map_addr_t;  // width of the address map below

    localparam map_addr_t ctrl_win_addr = 13'h1000; // whole control register window
    localparam map_addr_t ctrl_win_mask = 13'h1400;
    localparam map_addr_t busy_win_addr = 13'h1800; // bursts here may see busy
    localparam map_addr_t busy_win_mask = 13'h1c00;

    localparam map_addr_t dly_ld_addr   = 13'h1080; // 128 delay registers
    localparam map_addr_t dly_ld_mask   = 13'h1780;
    localparam map_addr_t dly_set_addr  = 13'h1070; // apply all delays at once
    localparam map_addr_t dly_set_mask  = 13'h17ff;
    localparam map_addr_t run_cmd_addr  = 13'h1000; // low 4 address bits give the channel
    localparam map_addr_t run_cmd_mask  = 13'h17f0;
    localparam map_addr_t patterns_addr = 13'h1020; // {dqm, dqs}
    localparam map_addr_t patterns_mask = 13'h17ff;
    localparam map_addr_t tri_addr      = 13'h1021; // {dqs_off, dqs_on, dq_off, dq_on}
    localparam map_addr_t tri_mask      = 13'h17ff;
    localparam map_addr_t wbuf_addr     = 13'h1022;
    localparam map_addr_t wbuf_mask     = 13'h17ff;
    localparam map_addr_t cmda_en_addr  = 13'h1024; // address bit 0 is the new value
    localparam map_addr_t cmda_en_mask  = 13'h17fe;
    localparam map_addr_t sdrst_addr    = 13'h1026;
    localparam map_addr_t sdrst_mask    = 13'h17fe;
    localparam map_addr_t cke_addr      = 13'h1028;
    localparam map_addr_t cke_mask      = 13'h17fe;

    localparam pattern_t  dqs_pattern_dflt = 8'h55; // toggling dqs during writes
    localparam pattern_t  dqm_pattern_dflt = 8'h00; // all bytes enabled
    localparam tri_pat_t  dq_tri_on_dflt   = 4'h7;
    localparam tri_pat_t  dq_tri_off_dflt  = 4'he;
    localparam tri_pat_t  dqs_tri_on_dflt  = 4'h3; // dqs preamble opens earlier than dq
    localparam tri_pat_t  dqs_tri_off_dflt = 4'hc;
    localparam wbuf_dly_t wbuf_dly_dflt    = 4'h6;

    // true when a agrees with addr on every bit set in mask
    function automatic logic addr_hit(input map_addr_t a, input map_addr_t addr,
                                      input map_addr_t mask);
        return ((a ^ addr) & mask) == '0;
    endfunction

endpackage

`default_nettype wire

// ==== src/ctrl_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_window #(
    parameter int addr_bits = 13
) (
    input  wire logic                 clk,
    input  wire logic                 mclk,
    input  wire logic                 start_wburst, // one-cycle burst start
    input  wire logic [addr_bits-1:0] pre_waddr,    // burst address, valid with start_wburst
    input  wire logic                 wr_en,
    input  wire logic                 half_empty,   // fifo at most half occupied
    output logic                      busy,
    output logic                      push          // fifo write
);
    import ddrc_ctrl_pkg::*;

    logic selected;      // current burst goes to the control registers
    logic selected_busy; // current burst lies in the busy window
    logic fill_high;     // fifo past half full, registered
    logic ctrl_match;
    logic busy_match;

    assign ctrl_match = addr_hit(pre_waddr[12:0], ctrl_win_addr, ctrl_win_mask);
    assign busy_match = addr_hit(pre_waddr[12:0], busy_win_addr, busy_win_mask);

    always_ff @(posedge clk or posedge mclk) begin
        if (mclk) begin
            selected      <= 1'b0;
            selected_busy <= 1'b0;
            fill_high     <= 1'b0;
        end else begin
            if (start_wburst) begin
                selected      <= ctrl_match;
                selected_busy <= busy_match;
            end
            fill_high <= !half_empty; // sampled every cycle so busy clears as the fifo drains
        end
    end

    // live address in the start cycle, latched window for the rest of the burst
    assign busy = fill_high && (start_wburst ? busy_match : selected_busy);
    assign push = wr_en && selected;

endmodule

`default_nettype wire

// ==== src/cmd_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo #(
    parameter int addr_bits       = 13,
    parameter int fifo_depth_log2 = 2
) (
    input  wire logic                  clk,
    input  wire logic                  mclk,
    input  wire logic                  push,
    input  wire logic [addr_bits-1:0]  push_addr,
    input  wire ddrc_ctrl_pkg::wdata_t push_data,
    input  wire logic                  pop,
    output logic [addr_bits-1:0]       head_addr,  // valid while nempty
    output ddrc_ctrl_pkg::wdata_t      head_data,
    output logic                       nempty,
    output logic                       half_empty  // at most half the entries in use
);
    import ddrc_ctrl_pkg::*;

    localparam int fifo_depth = 1 << fifo_depth_log2;

    logic [addr_bits-1:0]       mem_addr [fifo_depth]; // address half of each entry
    wdata_t                     mem_data [fifo_depth];
    logic [fifo_depth_log2-1:0] wptr;
    logic [fifo_depth_log2-1:0] rptr;
    logic [fifo_depth_log2:0]   count;
    logic                       full;
    logic                       push_ok;
    logic                       pop_ok;

    assign full       = count == (fifo_depth_log2 + 1)'(fifo_depth);
    assign nempty     = count != '0;
    assign half_empty = count <= (fifo_depth_log2 + 1)'(fifo_depth / 2);
    assign push_ok    = push && !full; // overflow beats are lost
    assign pop_ok     = pop && nempty;

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem_addr[wptr] <= push_addr;
            mem_data[wptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge mclk) begin
        if (mclk) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (push_ok) wptr <= wptr + 1'b1;
            if (pop_ok)  rptr <= rptr + 1'b1;
            unique case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle or simultaneous push and pop
            endcase
        end
    end

    assign head_addr = mem_addr[rptr]; // first word falls through
    assign head_data = mem_data[rptr];

    // master must respect busy, so the fifo never sees a write while full
    assert property (@(posedge clk) disable iff (mclk) push |-> !full)
        else $error("cmd_fifo: write into full fifo");
    assert property (@(posedge clk) disable iff (mclk) pop |-> nempty)
        else $error("cmd_fifo: read from empty fifo");

endmodule

`default_nettype wire

// ==== src/cmd_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_decode #(
    parameter int addr_bits = 13
) (
    input  wire logic                  clk,
    input  wire logic                  mclk,
    input  wire logic                  nempty,
    input  wire logic [addr_bits-1:0]  head_addr,
    input  wire ddrc_ctrl_pkg::wdata_t head_data,
    input  wire logic                  ddr_rst,    // memory held in reset, no sequencer runs
    output logic                       pop,
    output logic                       ld_delay,   // one-cycle delay register write
    output logic                       dly_set,    // one-cycle apply of all delays
    output logic                       run_seq,
    output ddrc_ctrl_pkg::dly_data_t   dly_data,
    output ddrc_ctrl_pkg::dly_addr_t   dly_addr,
    output ddrc_ctrl_pkg::run_addr_t   run_addr,
    output ddrc_ctrl_pkg::run_chn_t    run_chn,
    output logic                       ld_patterns,
    output logic                       ld_tri,
    output logic                       ld_wbuf,
    output logic                       ld_cmda,
    output logic                       ld_sdrst,
    output logic                       ld_cke,
    output logic                       set_bit,    // head address bit 0
    output logic [15:0]                set_data    // low half of the data word
);
    import ddrc_ctrl_pkg::*;

    map_addr_t a;
    logic      run_hit; // registered run match, before the memory reset gate

    assign pop = nempty; // one entry consumed every cycle
    assign a   = head_addr[12:0];

    always_ff @(posedge clk or posedge mclk) begin
        if (mclk) begin
            ld_delay    <= 1'b0;
            dly_set     <= 1'b0;
            run_hit     <= 1'b0;
            ld_patterns <= 1'b0;
            ld_tri      <= 1'b0;
            ld_wbuf     <= 1'b0;
            ld_cmda     <= 1'b0;
            ld_sdrst    <= 1'b0;
            ld_cke      <= 1'b0;
        end else begin
            ld_delay    <= pop && addr_hit(a, dly_ld_addr, dly_ld_mask);
            dly_set     <= pop && addr_hit(a, dly_set_addr, dly_set_mask);
            run_hit     <= pop && addr_hit(a, run_cmd_addr, run_cmd_mask);
            ld_patterns <= pop && addr_hit(a, patterns_addr, patterns_mask);
            ld_tri      <= pop && addr_hit(a, tri_addr, tri_mask);
            ld_wbuf     <= pop && addr_hit(a, wbuf_addr, wbuf_mask);
            ld_cmda     <= pop && addr_hit(a, cmda_en_addr, cmda_en_mask);
            ld_sdrst    <= pop && addr_hit(a, sdrst_addr, sdrst_mask);
            ld_cke      <= pop && addr_hit(a, cke_addr, cke_mask);
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dly_data <= head_data[7:0];
            dly_addr <= head_addr[6:0];
            run_addr <= head_data[10:0];
            run_chn  <= head_addr[3:0];
            set_bit  <= head_addr[0];
            set_data <= head_data[15:0];
        end
    end

    assign run_seq = run_hit && !ddr_rst;

    assert property (@(posedge clk) disable iff (mclk) !(ld_delay && dly_set))
        else $error("cmd_decode: delay load and delay set in the same cycle");

endmodule

`default_nettype wire

// ==== src/phy_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module phy_ctrl_regs (
    input  wire logic                clk,
    input  wire logic                mclk,
    input  wire logic                ld_patterns,
    input  wire logic                ld_tri,
    input  wire logic                ld_wbuf,
    input  wire logic                ld_cmda,
    input  wire logic                ld_sdrst,
    input  wire logic                ld_cke,
    input  wire logic                set_bit,
    input  wire logic [15:0]         set_data,
    output logic                     cmda_en,             // command/address outputs driven
    output logic                     ddr_rst,             // memory reset, asserted from power-up
    output logic                     ddr_cke,
    output ddrc_ctrl_pkg::pattern_t  dqs_pattern,
    output ddrc_ctrl_pkg::pattern_t  dqm_pattern,
    output ddrc_ctrl_pkg::tri_pat_t  dq_tri_on_pattern,
    output ddrc_ctrl_pkg::tri_pat_t  dq_tri_off_pattern,
    output ddrc_ctrl_pkg::tri_pat_t  dqs_tri_on_pattern,
    output ddrc_ctrl_pkg::tri_pat_t  dqs_tri_off_pattern,
    output ddrc_ctrl_pkg::wbuf_dly_t wbuf_delay
);
    import ddrc_ctrl_pkg::*;

    always_ff @(posedge clk or posedge mclk) begin
        if (mclk) begin
            {dqm_pattern, dqs_pattern} <= {dqm_pattern_dflt, dqs_pattern_dflt};
            dq_tri_on_pattern   <= dq_tri_on_dflt;
            dq_tri_off_pattern  <= dq_tri_off_dflt;
            dqs_tri_on_pattern  <= dqs_tri_on_dflt;
            dqs_tri_off_pattern <= dqs_tri_off_dflt;
            wbuf_delay          <= wbuf_dly_dflt;
            cmda_en             <= 1'b0;
            ddr_rst             <= 1'b1;
            ddr_cke             <= 1'b0;
        end else begin
            if (ld_patterns) {dqm_pattern, dqs_pattern} <= set_data; // dqm in upper byte
            if (ld_tri) begin
                // nibbles low to high: dq on, dq off, dqs on, dqs off
                {dqs_tri_off_pattern, dqs_tri_on_pattern,
                 dq_tri_off_pattern, dq_tri_on_pattern} <= set_data;
            end
            if (ld_wbuf)  wbuf_delay <= set_data[3:0];
            if (ld_cmda)  cmda_en    <= set_bit;
            if (ld_sdrst) ddr_rst    <= set_bit; // h1026 releases, h1027 asserts
            if (ld_cke)   ddr_cke    <= set_bit;
        end
    end

endmodule

`default_nettype wire

// ==== src/ddrc_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddrc_control #(
    parameter int addr_bits       = 13, // bus address width
    parameter int fifo_depth_log2 = 2   // four command entries
) (
    input  wire logic                  clk,
    input  wire logic                  mclk,
    input  wire logic                  start_wburst,
    input  wire logic [addr_bits-1:0]  pre_waddr,
    input  wire logic                  wr_en,
    input  wire logic [addr_bits-1:0]  waddr,
    input  wire ddrc_ctrl_pkg::wdata_t wdata,
    output logic                       busy,
    output ddrc_ctrl_pkg::run_addr_t   run_addr,
    output ddrc_ctrl_pkg::run_chn_t    run_chn,
    output logic                       run_seq,
    output ddrc_ctrl_pkg::dly_data_t   dly_data,
    output ddrc_ctrl_pkg::dly_addr_t   dly_addr,
    output logic                       ld_delay,
    output logic                       dly_set,
    output logic                       cmda_en,
    output logic                       ddr_rst,
    output logic                       ddr_cke,
    output ddrc_ctrl_pkg::pattern_t    dqs_pattern,
    output ddrc_ctrl_pkg::pattern_t    dqm_pattern,
    output ddrc_ctrl_pkg::tri_pat_t    dq_tri_on_pattern,
    output ddrc_ctrl_pkg::tri_pat_t    dq_tri_off_pattern,
    output ddrc_ctrl_pkg::tri_pat_t    dqs_tri_on_pattern,
    output ddrc_ctrl_pkg::tri_pat_t    dqs_tri_off_pattern,
    output ddrc_ctrl_pkg::wbuf_dly_t   wbuf_delay
);
    import ddrc_ctrl_pkg::*;

    logic                 push;
    logic                 half_empty;
    logic                 nempty;
    logic                 pop;
    logic [addr_bits-1:0] head_addr;
    wdata_t               head_data;
    logic                 ld_patterns;
    logic                 ld_tri;
    logic                 ld_wbuf;
    logic                 ld_cmda;
    logic                 ld_sdrst;
    logic                 ld_cke;
    logic                 set_bit;
    logic [15:0]          set_data;

    ctrl_window #(.addr_bits(addr_bits)) u_ctrl_window (
        .clk(clk), .mclk(mclk), .start_wburst(start_wburst), .pre_waddr(pre_waddr),
        .wr_en(wr_en), .half_empty(half_empty), .busy(busy), .push(push)
    );

    cmd_fifo #(.addr_bits(addr_bits), .fifo_depth_log2(fifo_depth_log2)) u_cmd_fifo (
        .clk(clk), .mclk(mclk), .push(push), .push_addr(waddr), .push_data(wdata),
        .pop(pop), .head_addr(head_addr), .head_data(head_data), .nempty(nempty),
        .half_empty(half_empty)
    );

    cmd_decode #(.addr_bits(addr_bits)) u_cmd_decode (
        .clk(clk), .mclk(mclk), .nempty(nempty), .head_addr(head_addr),
        .head_data(head_data), .ddr_rst(ddr_rst), .pop(pop), .ld_delay(ld_delay),
        .dly_set(dly_set), .run_seq(run_seq), .dly_data(dly_data), .dly_addr(dly_addr),
        .run_addr(run_addr), .run_chn(run_chn), .ld_patterns(ld_patterns),
        .ld_tri(ld_tri), .ld_wbuf(ld_wbuf), .ld_cmda(ld_cmda), .ld_sdrst(ld_sdrst),
        .ld_cke(ld_cke), .set_bit(set_bit), .set_data(set_data)
    );

    phy_ctrl_regs u_phy_ctrl_regs (
        .clk(clk), .mclk(mclk), .ld_patterns(ld_patterns), .ld_tri(ld_tri),
        .ld_wbuf(ld_wbuf), .ld_cmda(ld_cmda), .ld_sdrst(ld_sdrst), .ld_cke(ld_cke),
        .set_bit(set_bit), .set_data(set_data), .cmda_en(cmda_en), .ddr_rst(ddr_rst),
        .ddr_cke(ddr_cke), .dqs_pattern(dqs_pattern), .dqm_pattern(dqm_pattern),
        .dq_tri_on_pattern(dq_tri_on_pattern), .dq_tri_off_pattern(dq_tri_off_pattern),
        .dqs_tri_on_pattern(dqs_tri_on_pattern),
        .dqs_tri_off_pattern(dqs_tri_off_pattern), .wbuf_delay(wbuf_delay)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int half_period  = 20, // ns, 40 ns clock
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic mclk
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        mclk = 1'b1;                        // reset from time zero
        repeat (reset_cycles) @(posedge clk);
        mclk <= 1'b0;                       // released on a rising edge
    end

endmodule

`default_nettype wire

// ==== test/tb_ddrc_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ddrc_control;
    import ddrc_ctrl_pkg::*;

    localparam int reset_cycles    = 8;
    localparam int n_writes        = 42;   // bursts issued by the stimulus below
    localparam logic [1:0] stb_none = 2'd0;
    localparam logic [1:0] stb_dly  = 2'd1; // ld_delay pulse
    localparam logic [1:0] stb_set  = 2'd2; // dly_set pulse
    localparam logic [1:0] stb_run  = 2'd3; // run_seq pulse

    typedef struct packed {
        logic      cmda_en;
        logic      ddr_rst;
        logic      ddr_cke;
        pattern_t  dqs;
        pattern_t  dqm;
        tri_pat_t  dq_on;
        tri_pat_t  dq_off;
        tri_pat_t  dqs_on;
        tri_pat_t  dqs_off;
        wbuf_dly_t wbuf;
    } settings_t;

    typedef struct packed {
        logic [1:0] kind;
        dly_data_t  dly_data;
        dly_addr_t  dly_addr;
        run_addr_t  run_addr;
        run_chn_t   run_chn;
    } strobe_t;

    logic        clk;
    logic        mclk;
    logic        start_wburst;
    logic [12:0] pre_waddr;
    logic        wr_en;
    logic [12:0] waddr;
    wdata_t      wdata;
    logic        busy;
    run_addr_t   run_addr;
    run_chn_t    run_chn;
    logic        run_seq;
    dly_data_t   dly_data;
    dly_addr_t   dly_addr;
    logic        ld_delay;
    logic        dly_set;
    logic        cmda_en;
    logic        ddr_rst;
    logic        ddr_cke;
    pattern_t    dqs_pattern;
    pattern_t    dqm_pattern;
    tri_pat_t    dq_tri_on_pattern;
    tri_pat_t    dq_tri_off_pattern;
    tri_pat_t    dqs_tri_on_pattern;
    tri_pat_t    dqs_tri_off_pattern;
    wbuf_dly_t   wbuf_delay;

    int          errors = 0;
    int          checks = 0;
    bit          monitor_on = 1'b0;
    int unsigned seed = 65422;
    settings_t   model;     // expected settings once every issued write has landed
    settings_t   seen;      // last settings seen on the outputs
    settings_t   now_set;
    settings_t   exp_set;
    strobe_t     exp_stb;
    settings_t   set_q[$];  // settings changes still to come in write order
    strobe_t     stb_q[$];  // strobe pulses still to come

    tb_clock_gen #(.half_period(20), .reset_cycles(reset_cycles)) u_clock_gen (
        .clk(clk), .mclk(mclk)
    );

    ddrc_control #(.addr_bits(13), .fifo_depth_log2(2)) u_ddrc_control (.*);

    task automatic report_error(input string msg);
        errors++;
        $display("[ERROR] t=%0d ns: %s", $time, msg);
    endtask

    task automatic check_pattern(input string what, input pattern_t got, input pattern_t exp);
        checks++;
        if (got !== exp) report_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_tri(input string what, input tri_pat_t got, input tri_pat_t exp);
        checks++;
        if (got !== exp) report_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_wbuf(input wbuf_dly_t got, input wbuf_dly_t exp);
        checks++;
        if (got !== exp) report_error($sformatf("wbuf_delay is %h, expected %h", got, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) report_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_dly(input dly_data_t got_data, input dly_addr_t got_addr,
                             input dly_data_t exp_data, input dly_addr_t exp_addr);
        checks++;
        if (got_data !== exp_data || got_addr !== exp_addr)
            report_error($sformatf("delay load %h@%h, expected %h@%h",
                                   got_data, got_addr, exp_data, exp_addr));
    endtask

    task automatic check_run(input run_addr_t got_addr, input run_chn_t got_chn,
                             input run_addr_t exp_addr, input run_chn_t exp_chn);
        checks++;
        if (got_addr !== exp_addr || got_chn !== exp_chn)
            report_error($sformatf("run chn %h addr %h, expected chn %h addr %h",
                                   got_chn, got_addr, exp_chn, exp_addr));
    endtask

    function automatic settings_t current_settings();
        return '{cmda_en: cmda_en, ddr_rst: ddr_rst, ddr_cke: ddr_cke,
                 dqs: dqs_pattern, dqm: dqm_pattern,
                 dq_on: dq_tri_on_pattern, dq_off: dq_tri_off_pattern,
                 dqs_on: dqs_tri_on_pattern, dqs_off: dqs_tri_off_pattern,
                 wbuf: wbuf_delay};
    endfunction

    task automatic compare_settings(input settings_t got, input settings_t exp);
        check_bit("cmda_en", got.cmda_en, exp.cmda_en);
        check_bit("ddr_rst", got.ddr_rst, exp.ddr_rst);
        check_bit("ddr_cke", got.ddr_cke, exp.ddr_cke);
        check_pattern("dqs_pattern", got.dqs, exp.dqs);
        check_pattern("dqm_pattern", got.dqm, exp.dqm);
        check_tri("dq_tri_on", got.dq_on, exp.dq_on);
        check_tri("dq_tri_off", got.dq_off, exp.dq_off);
        check_tri("dqs_tri_on", got.dqs_on, exp.dqs_on);
        check_tri("dqs_tri_off", got.dqs_off, exp.dqs_off);
        check_wbuf(got.wbuf, exp.wbuf);
    endtask

    // expected effect of one register write on the settings and the strobes
    function automatic void expected_effect(input settings_t cur, input logic [12:0] a,
                                            input wdata_t d, output settings_t nxt,
                                            output strobe_t stb);
        nxt = cur;
        stb = '0;
        if ((a & 13'h1780) == 13'h1080) begin
            stb.kind     = stb_dly;
            stb.dly_data = d[7:0];
            stb.dly_addr = a[6:0];
        end else if ((a & 13'h17ff) == 13'h1070) begin
            stb.kind = stb_set;
        end else if ((a & 13'h17f0) == 13'h1000) begin
            if (!cur.ddr_rst) begin                          // no runs while memory in reset
                stb.kind     = stb_run;
                stb.run_addr = d[10:0];
                stb.run_chn  = a[3:0];
            end
        end else if ((a & 13'h17ff) == 13'h1020) begin
            nxt.dqs = d[7:0];
            nxt.dqm = d[15:8];
        end else if ((a & 13'h17ff) == 13'h1021) begin
            {nxt.dqs_off, nxt.dqs_on, nxt.dq_off, nxt.dq_on} = d[15:0];
        end else if ((a & 13'h17ff) == 13'h1022) begin
            nxt.wbuf = d[3:0];
        end else if ((a & 13'h17fe) == 13'h1024) begin
            nxt.cmda_en = a[0];
        end else if ((a & 13'h17fe) == 13'h1026) begin
            nxt.ddr_rst = a[0];
        end else if ((a & 13'h17fe) == 13'h1028) begin
            nxt.ddr_cke = a[0];
        end
    endfunction

    task automatic write_burst(input logic [12:0] pre_a, input logic [12:0] a, input wdata_t d);
        bit granted;
        granted = 1'b0;
        while (!granted) begin
            @(posedge clk);
            start_wburst <= 1'b1;
            pre_waddr    <= pre_a;
            @(negedge clk);
            granted = !busy;            // busy in the start cycle keeps the burst pending
            if (!granted) begin
                @(posedge clk);
                start_wburst <= 1'b0;
            end
        end
        @(posedge clk);
        start_wburst <= 1'b0;
        wr_en        <= 1'b1;           // single data beat
        waddr        <= a;
        wdata        <= d;
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic issue_write(input logic [12:0] pre_a, input logic [12:0] a, input wdata_t d);
        settings_t nxt;
        strobe_t   stb;
        if ((pre_a & 13'h1400) == 13'h1000) begin   // burst lands in the control window
            expected_effect(model, a, d, nxt, stb);
            if (nxt != model) set_q.push_back(nxt);
            if (stb.kind != stb_none) stb_q.push_back(stb);
            model = nxt;
        end
        write_burst(pre_a, a, d);
    endtask

    always @(negedge clk) begin
        if (monitor_on) begin
            if (start_wburst && busy && (pre_waddr & 13'h1c00) != 13'h1800)
                report_error("busy in a start cycle outside the busy window");
            now_set = current_settings();
            if (now_set != seen) begin
                if (set_q.size() == 0) begin
                    report_error("settings changed with no write pending");
                end else begin
                    exp_set = set_q.pop_front();
                    compare_settings(now_set, exp_set);
                end
                seen = now_set;
            end
            if (ld_delay || dly_set || run_seq) begin
                if (stb_q.size() == 0) begin
                    report_error("strobe pulse with no write pending");
                end else begin
                    exp_stb = stb_q.pop_front();
                    check_bit("ld_delay", ld_delay, exp_stb.kind == stb_dly);
                    check_bit("dly_set", dly_set, exp_stb.kind == stb_set);
                    check_bit("run_seq", run_seq, exp_stb.kind == stb_run);
                    if (exp_stb.kind == stb_dly)
                        check_dly(dly_data, dly_addr, exp_stb.dly_data, exp_stb.dly_addr);
                    if (exp_stb.kind == stb_run)
                        check_run(run_addr, run_chn, exp_stb.run_addr, exp_stb.run_chn);
                end
            end
        end
    end

    initial begin
        repeat (reset_cycles + 200 * n_writes) @(posedge clk);
        $display("timeout: the register writes did not complete in time");
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [12:0] a;
        void'($urandom(seed));
        start_wburst <= 1'b0;
        pre_waddr    <= '0;
        wr_en        <= 1'b0;
        waddr        <= '0;
        wdata        <= '0;
        wait (mclk === 1'b1);
        wait (mclk === 1'b0);
        @(negedge clk);
        model = '{cmda_en: 1'b0, ddr_rst: 1'b1, ddr_cke: 1'b0, dqs: 8'h55, dqm: 8'h00,
                  dq_on: 4'h7, dq_off: 4'he, dqs_on: 4'h3, dqs_off: 4'hc, wbuf: 4'h6};
        compare_settings(current_settings(), model);
        check_bit("busy", busy, 1'b0);
        check_bit("ld_delay", ld_delay, 1'b0);
        check_bit("dly_set", dly_set, 1'b0);
        check_bit("run_seq", run_seq, 1'b0);
        seen       = current_settings();
        monitor_on = 1'b1;
        repeat (12) begin                                   // patterns, tri, wbuf
            a = 13'h1020 + 13'($urandom_range(2, 0));
            issue_write(a, a, $urandom);
        end
        repeat (6) begin
            a = 13'h1080 | 13'($urandom_range(127, 0));
            issue_write(a, a, $urandom);
        end
        repeat (2) issue_write(13'h1070, 13'h1070, $urandom);
        repeat (3) begin                                    // memory still in reset
            a = 13'h1000 | 13'($urandom_range(15, 0));
            issue_write(a, a, $urandom);
        end
        repeat (10) begin                                   // cmda_en, ddr_rst, ddr_cke
            a = 13'h1024 + 13'($urandom_range(5, 0));
            issue_write(a, a, $urandom);
        end
        issue_write(13'h1026, 13'h1026, '0);                // release memory reset
        repeat (4) begin
            a = 13'h1000 | 13'($urandom_range(15, 0));
            issue_write(a, a, $urandom);
        end
        repeat (4) begin                                    // burst starts outside the window
            a = 13'h1020 + 13'($urandom_range(2, 0));
            issue_write(13'($urandom_range(4095, 0)), a, $urandom);
        end
        while (set_q.size() != 0 || stb_q.size() != 0) @(posedge clk);
        repeat (4) @(negedge clk);                          // past the two-cycle setting latency
        compare_settings(current_settings(), model);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
src/ddrc_ctrl_pkg.sv
src/ctrl_window.sv
src/cmd_fifo.sv
src/cmd_decode.sv
src/phy_ctrl_regs.sv
src/ddrc_control.sv
test/tb_clock_gen.sv
test/tb_ddrc_control.sv

// ==== Bender.yml ====
package:
  name: ddrc_control

sources:
  - src/ddrc_ctrl_pkg.sv
  - src/ctrl_window.sv
  - src/cmd_fifo.sv
  - src/cmd_decode.sv
  - src/phy_ctrl_regs.sv
  - src/ddrc_control.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_ddrc_control.sv
